/* project.f */
design/pipePkg.sv
design/regFile.sv
design/decodeStage.sv
design/forwardingLogic.sv
design/executeStage.sv
design/pipeCore.sv
tests/pipeCore_assert.sv
tests/pipeCoreTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = pipeCoreTb
FILELIST = project.f
OBJDIR   = obj_dir
LOG      = sim.log
SIMARGS  = +verilator+error+limit+1000
FAILMSG  = tests failed
PASSMSG  = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) $(SIMARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASSMSG)" $(LOG) || (echo "Simulation ended early, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tests/pipeCoreTb.sv */
// ######################################################################
// Pipeline testbench
// Directed and LFSR instruction streams into the core, every retired
// write compared against a register model
// ######################################################################
`timescale 1ns/10ps

module pipeCoreTb;
	import pipePkg::*;

	localparam int clkPeriod = 8;
	localparam int resetCycles = 3;
	localparam int randCount = 400;
	// Directed slots plus random slots at the longest gap
	localparam int issueSlots = 150 + randCount * 4;

	logic clk;
	logic rstN;
	logic instrValid;
	logic [instrWidth-1:0] instr;
	logic wbValid;
	logic [regAddrWidth-1:0] wbAddr;
	logic [dataWidth-1:0] wbData;

	// Register model and expected retire order
	logic [dataWidth-1:0] model [numRegs];
	logic [regAddrWidth-1:0] expAddrQ [$];
	logic [dataWidth-1:0] expDataQ [$];
	string expTestQ [$];
	logic [regAddrWidth-1:0] expAddr;
	logic [dataWidth-1:0] expData;
	string expTest;
	logic [31:0] lfsr;
	int errorCount;
	int totalErrors;

	pipeCore dut0 (
		.clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
		.wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Fibonacci taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic takeBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [15:0] regInstr(input logic [3:0] op, input logic [3:0] dst,
			input logic [3:0] s1, input logic [3:0] s0);
		return {op, dst, s1, s0};
	endfunction

	function automatic logic [15:0] immInstr(input logic [3:0] op, input logic [3:0] dst,
			input logic [7:0] imm);
		return {op, dst, imm};
	endfunction

	// Drive one word and retire it in the model
	task automatic issue(input logic [15:0] word, input string testName);
		logic [3:0] op;
		logic [3:0] dst;
		logic [15:0] res;
		op = word[15:12];
		dst = word[11:8];
		@(negedge clk);
		instrValid = 1'b1;
		instr = word;
		case (op)
			opAdd: res = model[word[7:4]] + model[word[3:0]];
			opSub: res = model[word[7:4]] - model[word[3:0]];
			opAnd: res = model[word[7:4]] & model[word[3:0]];
			opOr: res = model[word[7:4]] | model[word[3:0]];
			opXor: res = model[word[7:4]] ^ model[word[3:0]];
			opLdi: res = {8'h00, word[7:0]};
			opAddi: res = model[dst] + {{8{word[7]}}, word[7:0]};
			default: res = '0;
		endcase
		// NOP and register 0 retire silently
		if ((op != opNop) && (dst != 4'd0)) begin
			model[dst] = res;
			expAddrQ.push_back(dst);
			expDataQ.push_back(res);
			expTestQ.push_back(testName);
		end
	endtask

	task automatic nops(input int n, input string testName);
		for (int i = 0; i < n; i++)
			issue(16'h0000, testName);
	endtask

	task automatic idle(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			instrValid = 1'b0;
		end
	endtask

	// Write-back checker
	always @(posedge clk) begin
		if (rstN && wbValid) begin
			assert (expAddrQ.size() > 0)
			else begin
				$display("Write-back to r%0d arrived with no result expected", wbAddr);
				errorCount++;
			end
			if (expAddrQ.size() > 0) begin
				expAddr = expAddrQ.pop_front();
				expData = expDataQ.pop_front();
				expTest = expTestQ.pop_front();
				assert (wbAddr == expAddr)
				else begin
					$display("ERR %s wbAddr expected %0d actual %0d", expTest, expAddr, wbAddr);
					errorCount++;
				end
				assert (wbData == expData)
				else begin
					$display("ERR %s wbData expected %h actual %h", expTest, expData, wbData);
					errorCount++;
				end
			end
		end
	end

	// Watchdog
	initial begin
		#((issueSlots + resetCycles) * clkPeriod + 200);
		$display("Timeout, write-back queue did not drain with %0d results left",
			expAddrQ.size());
		$display("Summary: %0d check errors, %0d assertion errors", errorCount,
			dut0.assert0.violationCount);
		$display("tests failed");
		$finish;
	end

	initial begin
		logic [3:0] aluOp;
		logic [31:0] opBits;
		logic [31:0] fieldBits;
		logic [31:0] gapBits;
		lfsr = 32'h9e9225da;
		errorCount = 0;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		for (int i = 0; i < numRegs; i++)
			model[i] = '0;
		repeat (resetCycles) @(negedge clk);
		rstN = 1'b1;

		// Independent ALU ops, NOPs keep operands out of the pipe
		issue(immInstr(opLdi, 4'd1, 8'h5a), "independent");
		issue(immInstr(opLdi, 4'd2, 8'hc3), "independent");
		nops(4, "independent");
		for (aluOp = opAdd; aluOp <= opXor; aluOp++) begin
			issue(regInstr(aluOp, aluOp + 4'd2, 4'd1, 4'd2), "independent");
			nops(4, "independent");
		end

		// Back-to-back chain through the memory slot
		issue(immInstr(opLdi, 4'd1, 8'h07), "chain");
		issue(immInstr(opAddi, 4'd1, 8'hfd), "chain");
		issue(regInstr(opAdd, 4'd2, 4'd1, 4'd1), "chain");
		issue(regInstr(opSub, 4'd3, 4'd2, 4'd1), "chain");
		issue(regInstr(opXor, 4'd4, 4'd3, 4'd2), "chain");
		issue(regInstr(opOr, 4'd5, 4'd4, 4'd3), "chain");
		issue(immInstr(opAddi, 4'd5, 8'h80), "chain");
		idle(4);

		// r9 two back, r8 three back
		issue(immInstr(opLdi, 4'd8, 8'h21), "distance");
		issue(immInstr(opLdi, 4'd9, 8'h40), "distance");
		nops(1, "distance");
		issue(regInstr(opAdd, 4'd10, 4'd9, 4'd8), "distance");
		nops(1, "distance");
		issue(regInstr(opAnd, 4'd11, 4'd10, 4'd8), "distance");
		// Idle gap puts r11 three back
		idle(2);
		issue(regInstr(opSub, 4'd12, 4'd11, 4'd10), "distance");
		idle(4);

		// Same source twice, both producers in flight
		issue(immInstr(opLdi, 4'd6, 8'h11), "priority");
		issue(immInstr(opLdi, 4'd6, 8'h22), "priority");
		issue(regInstr(opAdd, 4'd7, 4'd6, 4'd6), "priority");
		issue(immInstr(opAddi, 4'd7, 8'h01), "priority");
		issue(immInstr(opAddi, 4'd7, 8'h01), "priority");
		issue(regInstr(opXor, 4'd13, 4'd7, 4'd7), "priority");
		idle(4);

		// Writes to r0 vanish, r0 reads zero
		issue(immInstr(opLdi, 4'd0, 8'hff), "zeroReg");
		issue(regInstr(opAdd, 4'd0, 4'd1, 4'd2), "zeroReg");
		issue(immInstr(opAddi, 4'd0, 8'h05), "zeroReg");
		nops(2, "zeroReg");
		issue(regInstr(opAdd, 4'd14, 4'd0, 4'd3), "zeroReg");
		issue(regInstr(opOr, 4'd15, 4'd0, 4'd0), "zeroReg");
		idle(6);

		// Random stream, opcodes 0 to 7, gaps of up to three cycles
		for (int n = 0; n < randCount; n++) begin
			takeBits(3, opBits);
			takeBits(12, fieldBits);
			issue({1'b0, opBits[2:0], fieldBits[11:0]}, "random");
			takeBits(3, gapBits);
			if (gapBits[2:0] > 3'd4)
				idle(int'(gapBits[2:0]) - 4);
		end
		idle(1);

		while (expAddrQ.size() != 0)
			@(posedge clk);
		// Room for a stray write-back
		repeat (8) @(posedge clk);
		totalErrors = errorCount + dut0.assert0.violationCount;
		$display("Summary: %0d check errors, %0d assertion errors", errorCount,
			dut0.assert0.violationCount);
		if (totalErrors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* tests/pipeCore_assert.sv */
// ######################################################################
// Pipeline assertions
// Forwarding priority and write-back port rules, bound into the core
// ######################################################################
`timescale 1ns/10ps

module pipeCoreAssert (
	input logic                             clk,
	input logic                             rstN,
	input logic                             memWe,
	input logic [pipePkg::regAddrWidth-1:0] memDst,
	input logic                             wbWe,
	input logic [pipePkg::regAddrWidth-1:0] wbDst,
	input logic [pipePkg::regAddrWidth-1:0] srcA,
	input logic [pipePkg::regAddrWidth-1:0] srcB,
	input logic [pipePkg::fwdSelWidth-1:0]  forwardA,
	input logic [pipePkg::fwdSelWidth-1:0]  forwardB,
	input logic                             wbValid,
	input logic [pipePkg::regAddrWidth-1:0] wbAddr
);
	import pipePkg::*;

	// Failed assertion count
	int violationCount = 0;

	logic bothHitA;
	logic bothHitB;

	// Both in-flight producers target the same source
	assign bothHitA = memWe && wbWe && (memDst != '0) && (memDst == srcA) && (wbDst == srcA);
	assign bothHitB = memWe && wbWe && (memDst != '0) && (memDst == srcB) && (wbDst == srcB);

	memFirstA: assert property (@(posedge clk) disable iff (!rstN)
		bothHitA |-> (forwardA == fwdMem))
	else begin
		$error("operand A took the older producer");
		violationCount++;
	end

	memFirstB: assert property (@(posedge clk) disable iff (!rstN)
		bothHitB |-> (forwardB == fwdMem))
	else begin
		$error("operand B took the older producer");
		violationCount++;
	end

	// Register 0 never retires on the port
	noZeroRetire: assert property (@(posedge clk) disable iff (!rstN)
		wbValid |-> (wbAddr != '0))
	else begin
		$error("write-back port shows register 0");
		violationCount++;
	end

endmodule

bind pipeCore pipeCoreAssert assert0 (
	.clk(clk), .rstN(rstN),
	.memWe(memWe), .memDst(memDst), .wbWe(wbWe), .wbDst(wbDst),
	.srcA(srcA), .srcB(srcB), .forwardA(forwardA), .forwardB(forwardB),
	.wbValid(wbValid), .wbAddr(wbAddr)
);

/* design/pipeCore.sv */
// ######################################################################
// Pipeline top
// Decode, execute, forwarding unit and register file; every retiring
// write is reported on the write-back port
// ######################################################################
`timescale 1ns/10ps

module pipeCore (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             instrValid,
	input  logic [pipePkg::instrWidth-1:0]   instr,
	output logic                             wbValid,
	output logic [pipePkg::regAddrWidth-1:0] wbAddr,
	output logic [pipePkg::dataWidth-1:0]    wbData
);
	import pipePkg::*;

	// Register read
	logic [regAddrWidth-1:0] rdAddrA;
	logic [regAddrWidth-1:0] rdAddrB;
	logic [dataWidth-1:0] rdDataA;
	logic [dataWidth-1:0] rdDataB;

	// Decode/execute register
	logic exValid;
	logic [opcodeWidth-1:0] exOp;
	logic [regAddrWidth-1:0] exDst;
	logic [regAddrWidth-1:0] exSrcA;
	logic [regAddrWidth-1:0] exSrcB;
	logic [dataWidth-1:0] exOperandA;
	logic [dataWidth-1:0] exOperandB;
	logic [immWidth-1:0] exImm;
	logic exWe;

	// Producers and forwarding selects
	logic [regAddrWidth-1:0] srcA;
	logic [regAddrWidth-1:0] srcB;
	logic memWe;
	logic [regAddrWidth-1:0] memDst;
	logic wbWe;
	logic [regAddrWidth-1:0] wbDst;
	logic [fwdSelWidth-1:0] forwardA;
	logic [fwdSelWidth-1:0] forwardB;

	regFile regFile0 (
		.clk(clk), .rstN(rstN),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
		.rdDataA(rdDataA), .rdDataB(rdDataB),
		// Write port driven from write-back
		.we(wbWe), .wrAddr(wbDst), .wrData(wbData)
	);

	decodeStage decodeStage0 (
		.clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
		.exValid(exValid), .exOp(exOp), .exDst(exDst), .exSrcA(exSrcA), .exSrcB(exSrcB),
		.exOperandA(exOperandA), .exOperandB(exOperandB), .exImm(exImm), .exWe(exWe)
	);

	forwardingLogic forwardingLogic0 (
		.memWe(memWe), .memDst(memDst), .wbWe(wbWe), .wbDst(wbDst),
		.srcA(srcA), .srcB(srcB), .forwardA(forwardA), .forwardB(forwardB)
	);

	executeStage executeStage0 (
		.clk(clk), .rstN(rstN),
		.exValid(exValid), .exOp(exOp), .exDst(exDst), .exSrcA(exSrcA), .exSrcB(exSrcB),
		.exOperandA(exOperandA), .exOperandB(exOperandB), .exImm(exImm), .exWe(exWe),
		.forwardA(forwardA), .forwardB(forwardB), .srcA(srcA), .srcB(srcB),
		.memWe(memWe), .memDst(memDst), .wbWe(wbWe), .wbDst(wbDst),
		.wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
	);

endmodule

/* design/executeStage.sv */
// ######################################################################
// Execute stage
// Operand muxes and ALU, then the memory-slot and write-back registers
// that feed the forwarding unit and the register file
// ######################################################################
`timescale 1ns/10ps

module executeStage (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             exValid,
	input  logic [pipePkg::opcodeWidth-1:0]  exOp,
	input  logic [pipePkg::regAddrWidth-1:0] exDst,
	input  logic [pipePkg::regAddrWidth-1:0] exSrcA,
	input  logic [pipePkg::regAddrWidth-1:0] exSrcB,
	input  logic [pipePkg::dataWidth-1:0]    exOperandA,
	input  logic [pipePkg::dataWidth-1:0]    exOperandB,
	input  logic [pipePkg::immWidth-1:0]     exImm,
	input  logic                             exWe,
	input  logic [pipePkg::fwdSelWidth-1:0]  forwardA,
	input  logic [pipePkg::fwdSelWidth-1:0]  forwardB,
	output logic [pipePkg::regAddrWidth-1:0] srcA,
	output logic [pipePkg::regAddrWidth-1:0] srcB,
	output logic                             memWe,
	output logic [pipePkg::regAddrWidth-1:0] memDst,
	output logic                             wbWe,
	output logic [pipePkg::regAddrWidth-1:0] wbDst,
	output logic                             wbValid,
	output logic [pipePkg::regAddrWidth-1:0] wbAddr,
	output logic [pipePkg::dataWidth-1:0]    wbData
);
	import pipePkg::*;

	logic [dataWidth-1:0] operandA;
	logic [dataWidth-1:0] operandB;
	logic [dataWidth-1:0] immSext;
	logic [dataWidth-1:0] immZext;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] memResult;
	logic memValid;
	logic wbValidQ;

	// Sources go out to the forwarding unit
	assign srcA = exSrcA;
	assign srcB = exSrcB;

	// Operand muxes
	always_comb begin
		case (forwardA)
			fwdMem: operandA = memResult;
			fwdWb: operandA = wbData;
			default: operandA = exOperandA;
		endcase
		case (forwardB)
			fwdMem: operandB = memResult;
			fwdWb: operandB = wbData;
			default: operandB = exOperandB;
		endcase
	end

	assign immSext = {{(dataWidth-immWidth){exImm[immWidth-1]}}, exImm};
	assign immZext = {{(dataWidth-immWidth){1'b0}}, exImm};

	// ALU
	always_comb begin
		case (exOp)
			opAdd: aluResult = operandA + operandB;
			opSub: aluResult = operandA - operandB;
			opAnd: aluResult = operandA & operandB;
			opOr: aluResult = operandA | operandB;
			opXor: aluResult = operandA ^ operandB;
			opLdi: aluResult = immZext;
			// Operand A holds the old destination value
			opAddi: aluResult = operandA + immSext;
			// Unused opcodes write zero
			default: aluResult = '0;
		endcase
	end

	// Memory slot, then write-back
	always_ff @(posedge clk) begin
		if (!rstN) begin
			memValid <= 1'b0;
			memWe <= 1'b0;
			memDst <= '0;
			wbValidQ <= 1'b0;
			wbWe <= 1'b0;
			wbDst <= '0;
		end else begin
			memValid <= exValid;
			memWe <= exWe;
			memDst <= exDst;
			wbValidQ <= memValid;
			wbWe <= memWe;
			wbDst <= memDst;
		end
		memResult <= aluResult;
		wbData <= memResult;
	end

	// Only retiring writes show on the port
	assign wbValid = wbValidQ && wbWe;
	assign wbAddr = wbDst;

endmodule

/* design/forwardingLogic.sv */
// ######################################################################
// Forwarding unit
// Picks each execute operand from memory slot, write-back or register
// file; the newer producer wins
// ######################################################################
`timescale 1ns/10ps

module forwardingLogic (
	input  logic                             memWe,
	input  logic [pipePkg::regAddrWidth-1:0] memDst,
	input  logic                             wbWe,
	input  logic [pipePkg::regAddrWidth-1:0] wbDst,
	input  logic [pipePkg::regAddrWidth-1:0] srcA,
	input  logic [pipePkg::regAddrWidth-1:0] srcB,
	output logic [pipePkg::fwdSelWidth-1:0]  forwardA,
	output logic [pipePkg::fwdSelWidth-1:0]  forwardB
);
	import pipePkg::*;

	// Same priority check for both operands
	function automatic logic [fwdSelWidth-1:0] pickSource(input logic [regAddrWidth-1:0] src);
		logic memHit;
		logic wbHit;
		// Register 0 is never a real producer
		memHit = memWe && (memDst != '0) && (memDst == src);
		wbHit = wbWe && (wbDst != '0) && (wbDst == src);
		if (memHit)
			return fwdMem;
		else if (wbHit)
			return fwdWb;
		else
			return fwdNone;
	endfunction

	// Operand A is source1 or the addi destination
	always_comb forwardA = pickSource(srcA);
	// Operand B is source0
	always_comb forwardB = pickSource(srcB);

endmodule

/* design/decodeStage.sv */
// ######################################################################
// Decode stage
// Latches the instruction, decodes it through the union, reads the
// register file and loads the decode/execute register
// ######################################################################
`timescale 1ns/10ps

module decodeStage (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             instrValid,
	input  logic [pipePkg::instrWidth-1:0]   instr,
	output logic [pipePkg::regAddrWidth-1:0] rdAddrA,
	output logic [pipePkg::regAddrWidth-1:0] rdAddrB,
	input  logic [pipePkg::dataWidth-1:0]    rdDataA,
	input  logic [pipePkg::dataWidth-1:0]    rdDataB,
	output logic                             exValid,
	output logic [pipePkg::opcodeWidth-1:0]  exOp,
	output logic [pipePkg::regAddrWidth-1:0] exDst,
	output logic [pipePkg::regAddrWidth-1:0] exSrcA,
	output logic [pipePkg::regAddrWidth-1:0] exSrcB,
	output logic [pipePkg::dataWidth-1:0]    exOperandA,
	output logic [pipePkg::dataWidth-1:0]    exOperandB,
	output logic [pipePkg::immWidth-1:0]     exImm,
	output logic                             exWe
);
	import pipePkg::*;

	logic instrValidQ;
	instrWord instrQ;
	logic [opcodeWidth-1:0] op;
	logic [regAddrWidth-1:0] dst;

	// Opcode and destination sit in the same bits in both views
	assign op = instrQ.regForm.op;
	assign dst = instrQ.regForm.dst;

	// Instruction latch, word itself is payload
	always_ff @(posedge clk) begin
		if (!rstN)
			instrValidQ <= 1'b0;
		else
			instrValidQ <= instrValid;
		if (instrValid)
			instrQ <= instr;
	end

	// Source selection per form
	always_comb begin
		rdAddrA = '0;
		rdAddrB = '0;
		if (op == opAddi) begin
			// Reads its own destination
			rdAddrA = instrQ.immForm.dst;
		end else if ((op != opLdi) && (op != opNop)) begin
			rdAddrA = instrQ.regForm.src1;
			rdAddrB = instrQ.regForm.src0;
		end
	end

	// Decode/execute register
	always_ff @(posedge clk) begin
		if (!rstN) begin
			exValid <= 1'b0;
			exWe <= 1'b0;
			exOp <= opNop;
			exDst <= '0;
			exSrcA <= '0;
			exSrcB <= '0;
		end else begin
			exValid <= instrValidQ;
			// No write for NOP or register 0
			exWe <= instrValidQ && (op != opNop) && (dst != '0);
			exOp <= op;
			exDst <= dst;
			exSrcA <= rdAddrA;
			exSrcB <= rdAddrB;
		end
		exOperandA <= rdDataA;
		exOperandB <= rdDataB;
		exImm <= instrQ.immForm.imm;
	end

endmodule

/* design/regFile.sv */
// ######################################################################
// Register file
// Sixteen registers with register 0 hardwired to zero; a write in the
// same cycle is passed straight through to a matching read
// ######################################################################
`timescale 1ns/10ps

module regFile (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic [pipePkg::regAddrWidth-1:0] rdAddrA,
	input  logic [pipePkg::regAddrWidth-1:0] rdAddrB,
	output logic [pipePkg::dataWidth-1:0]    rdDataA,
	output logic [pipePkg::dataWidth-1:0]    rdDataB,
	input  logic                             we,
	input  logic [pipePkg::regAddrWidth-1:0] wrAddr,
	input  logic [pipePkg::dataWidth-1:0]    wrData
);
	import pipePkg::*;

	logic [dataWidth-1:0] regs [numRegs];

	// Read logic for either port
	function automatic logic [dataWidth-1:0] readPort(input logic [regAddrWidth-1:0] addr);
		if (addr == '0)
			return '0;
		// Write-through for the producer retiring this cycle
		else if (we && (wrAddr == addr))
			return wrData;
		else
			return regs[addr];
	endfunction

	always_comb rdDataA = readPort(rdAddrA);
	always_comb rdDataB = readPort(rdAddrB);

	// Slot 0 is never written
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
		end else if (we && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule

/* design/pipePkg.sv */
// ######################################################################
// Pipeline package
// Widths, opcodes, forwarding codes and the two-view instruction word
// shared by every stage of the integer pipeline
// ######################################################################
package pipePkg;

	// Datapath and register file sizes
	localparam int dataWidth = 16;
	localparam int regAddrWidth = 4;
	localparam int numRegs = 1 << regAddrWidth;

	// Instruction word fields
	localparam int instrWidth = 16;
	localparam int opcodeWidth = 4;
	localparam int immWidth = 8;

	// Opcodes
	localparam logic [opcodeWidth-1:0] opNop = 4'h0;
	localparam logic [opcodeWidth-1:0] opAdd = 4'h1;
	localparam logic [opcodeWidth-1:0] opSub = 4'h2;
	localparam logic [opcodeWidth-1:0] opAnd = 4'h3;
	localparam logic [opcodeWidth-1:0] opOr = 4'h4;
	localparam logic [opcodeWidth-1:0] opXor = 4'h5;
	// Zero-extended immediate load
	localparam logic [opcodeWidth-1:0] opLdi = 4'h6;
	// dst = dst + sign-extended immediate
	localparam logic [opcodeWidth-1:0] opAddi = 4'h7;

	// Operand source select, memory slot has priority over write-back
	localparam int fwdSelWidth = 2;
	localparam logic [fwdSelWidth-1:0] fwdNone = 2'b00;
	localparam logic [fwdSelWidth-1:0] fwdWb = 2'b01;
	localparam logic [fwdSelWidth-1:0] fwdMem = 2'b10;

	// Register form, source1 feeds operand A and source0 operand B
	typedef struct packed {
		logic [opcodeWidth-1:0] op;
		logic [regAddrWidth-1:0] dst;
		logic [regAddrWidth-1:0] src1;
		logic [regAddrWidth-1:0] src0;
	} regFormT;

	// Immediate form
	typedef struct packed {
		logic [opcodeWidth-1:0] op;
		logic [regAddrWidth-1:0] dst;
		logic [immWidth-1:0] imm;
	} immFormT;

	// Same word, opcode picks the view
	typedef union packed {
		regFormT regForm;
		immFormT immForm;
	} instrWord;

endpackage
